// ==== design/ex_consts.svh ====
// data widths, flag bit positions and operand size codes for the execute stage
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// datapath widths
`define EX_WORD_W 32
`define EX_MM_W 64

// positions inside the 32-bit flags word
`define EX_FLAG_CF 0
`define EX_FLAG_AF 4
`define EX_FLAG_ZF 6
`define EX_FLAG_SF 7
`define EX_FLAG_OF 11

// operand size codes
`define EX_SIZE_W 2
`define EX_SZ_BYTE 2'd0
`define EX_SZ_WORD 2'd1
`define EX_SZ_DWORD 2'd2
`define EX_SZ_QUAD 2'd3

`endif

// ==== design/ex_pkg.sv ====
// operation enums, micro-op control struct and EX/WB payload structs
`default_nettype none

`include "ex_consts.svh"

package ex_pkg;

	// --------------------
	// operation codes
	// --------------------

	// bit 0 doubles as the shift direction, 0 is shl and 1 is shr
	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_adc    = 3'd1,
		alu_sub    = 3'd2,
		alu_sbb    = 3'd3,
		alu_and    = 3'd4,
		alu_or     = 3'd5,
		alu_xor    = 3'd6,
		alu_pass_b = 3'd7
	} alu_op_e;

	typedef enum logic [`EX_SIZE_W-1:0] {
		size_byte  = `EX_SZ_BYTE,
		size_word  = `EX_SZ_WORD,
		size_dword = `EX_SZ_DWORD,
		size_quad  = `EX_SZ_QUAD
	} data_size_e;

	typedef enum logic [1:0] {
		mm_paddb = 2'd0,
		mm_paddw = 2'd1,
		mm_paddd = 2'd2,
		mm_pand  = 2'd3
	} mm_op_e;

	// --------------------
	// control bundle
	// --------------------
	typedef struct packed {
		alu_op_e    alu_op;
		data_size_e size;
		mm_op_e     mm_op;
		logic       is_cmps_first;
		logic       is_cmps_second;
		logic       repne_steady;
		logic       is_cmpxchg;
		logic       is_xchg;
		logic       pass_a;
		logic       is_alu32;
		logic       alu32_flags_sel;
		logic       alu_to_b;
		logic       mux_sp_pop;
		logic       repne;
		// raw write enables from decode
		logic       ld_gpr1;
		logic       ld_gpr2;
		logic       ld_gpr3;
		logic       ld_seg;
		logic       ld_mm;
		logic       dcache_write;
	} ex_ctrl_t;

	// --------------------
	// EX/WB payloads
	// --------------------
	typedef struct packed {
		logic [`EX_WORD_W-1:0] result_a;
		logic [`EX_WORD_W-1:0] result_b;
		logic [`EX_WORD_W-1:0] result_c;
		logic [`EX_WORD_W-1:0] flags;
		logic [`EX_MM_W-1:0]   result_mm;
	} wb_data_t;

	// write enables here are already qualified by valid
	typedef struct packed {
		logic valid;
		logic ld_gpr1;
		logic ld_gpr2;
		logic ld_gpr3;
		logic ld_seg;
		logic ld_mm;
		logic dcache_write;
	} wb_ctrl_t;

endpackage

`default_nettype wire

// ==== design/fu_results_if.sv ====
// functional unit result bundle with producer and consumer modports
`default_nettype none

`include "ex_consts.svh"

interface fu_results_if;

	logic [`EX_WORD_W-1:0] alu32_result;
	logic [`EX_WORD_W-1:0] alu32_flags;
	logic [`EX_MM_W-1:0]   alu64_result;
	logic [`EX_WORD_W-1:0] shift_result;
	logic [`EX_WORD_W-1:0] shift_flags;
	logic [`EX_WORD_W-1:0] count_minus_one;
	logic [`EX_WORD_W-1:0] sp_pop;

	// driven by the functional units
	modport producer (
		output alu32_result,
		output alu32_flags,
		output alu64_result,
		output shift_result,
		output shift_flags,
		output count_minus_one,
		output sp_pop
	);

	// read by result selection and write control
	modport consumer (
		input alu32_result,
		input alu32_flags,
		input alu64_result,
		input shift_result,
		input shift_flags,
		input count_minus_one,
		input sp_pop
	);

endinterface

`default_nettype wire

// ==== design/stage_latch.sv ====
// type-parameterized pipeline register with load enable and synchronous clear
`default_nettype none

module stage_latch #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     load,
	input  payload_t d,
	output payload_t q
);

	// holds its value whenever load is low
	always_ff @(posedge clk) begin
		if (rst) begin
			q <= '0;
		end else if (load) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// ==== design/operand_select_ex.sv ====
// operand selection for EX with the cmps first-operand temporary
`default_nettype none

`include "ex_consts.svh"

module operand_select_ex (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ex_valid,
	input  logic                  wb_stall,
	input  ex_pkg::ex_ctrl_t      ctrl,
	input  logic [`EX_WORD_W-1:0] ex_a,
	input  logic [`EX_WORD_W-1:0] ex_b,
	input  logic [`EX_WORD_W-1:0] ex_c,
	input  logic [`EX_WORD_W-1:0] count_fwd,
	output logic [`EX_WORD_W-1:0] b,
	output logic [`EX_WORD_W-1:0] count
);

	logic [`EX_WORD_W-1:0] cmps_temp;
	logic                  cmps_temp_ld;

	// capture only when the first cmps uop actually advances
	assign cmps_temp_ld = ex_valid && ctrl.is_cmps_first && !wb_stall;

	always_ff @(posedge clk) begin
		if (rst) begin
			cmps_temp <= '0;
		end else if (cmps_temp_ld) begin
			cmps_temp <= ex_a;
		end
	end

	// second cmps uop compares against the saved first operand
	assign b = ctrl.is_cmps_second ? cmps_temp : ex_b;

	// steady-state repne takes the forwarded count
	assign count = ctrl.repne_steady ? count_fwd : ex_c;

endmodule

`default_nettype wire

// ==== design/functional_unit_ex.sv ====
// 32-bit ALU with flags, shifter, packed 64-bit adder, count decrement and pop adder
`default_nettype none

`include "ex_consts.svh"

module functional_unit_ex (
	input  ex_pkg::ex_ctrl_t      ctrl,
	input  logic [`EX_WORD_W-1:0] ex_a,
	input  logic [`EX_WORD_W-1:0] ex_b,
	input  logic [`EX_WORD_W-1:0] ex_c,
	input  logic [`EX_WORD_W-1:0] b,
	input  logic [`EX_WORD_W-1:0] count,
	input  logic [`EX_WORD_W-1:0] flags_fwd,
	input  logic [`EX_MM_W-1:0]   ex_mm_a,
	input  logic [`EX_MM_W-1:0]   ex_mm_b,
	fu_results_if.producer        fu
);

	// quad falls back to the full 32-bit path here
	function automatic logic [`EX_WORD_W-1:0] size_mask(input ex_pkg::data_size_e size);
		case (size)
			ex_pkg::size_byte: return 32'h0000_00ff;
			ex_pkg::size_word: return 32'h0000_ffff;
			default:           return 32'hffff_ffff;
		endcase
	endfunction

	// sign bit of the operand at the selected width
	function automatic logic top_bit(input logic [`EX_WORD_W-1:0] v,
		input ex_pkg::data_size_e size);
		case (size)
			ex_pkg::size_byte: return v[7];
			ex_pkg::size_word: return v[15];
			default:           return v[31];
		endcase
	endfunction

	// carry out just past the selected width
	function automatic logic carry_bit(input logic [`EX_WORD_W:0] v,
		input ex_pkg::data_size_e size);
		case (size)
			ex_pkg::size_byte: return v[8];
			ex_pkg::size_word: return v[16];
			default:           return v[32];
		endcase
	endfunction

	logic [`EX_WORD_W-1:0]   mask;
	logic [`EX_WORD_W-1:0]   a_m;
	logic [`EX_WORD_W-1:0]   b_m;
	logic                    cf_in;
	logic [`EX_WORD_W:0]     raw;
	logic [`EX_WORD_W-1:0]   alu_res;
	logic [`EX_WORD_W-1:0]   alu_flags;
	logic                    is_arith;
	logic                    is_sub;
	logic                    a_top;
	logic                    b_top;
	logic                    r_top;
	logic [4:0]              shamt;
	logic [2*`EX_WORD_W-1:0] shl_wide;
	logic [`EX_WORD_W:0]     shr_wide;
	logic [`EX_WORD_W-1:0]   shift_res;
	logic                    shift_cf;
	logic [`EX_WORD_W-1:0]   shift_flags;
	logic [`EX_MM_W-1:0]     mm_res;
	logic [`EX_WORD_W-1:0]   pop_inc;

	assign mask  = size_mask(ctrl.size);
	assign a_m   = ex_a & mask;
	assign b_m   = b & mask;
	assign cf_in = flags_fwd[`EX_FLAG_CF];

	// --------------------
	// alu32
	// --------------------

	// one extra bit keeps the carry or borrow at dword size
	always_comb begin
		case (ctrl.alu_op)
			ex_pkg::alu_add: raw = {1'b0, a_m} + {1'b0, b_m};
			ex_pkg::alu_adc: raw = {1'b0, a_m} + {1'b0, b_m} + cf_in;
			ex_pkg::alu_sub: raw = {1'b0, a_m} - {1'b0, b_m};
			ex_pkg::alu_sbb: raw = {1'b0, a_m} - {1'b0, b_m} - cf_in;
			ex_pkg::alu_and: raw = {1'b0, a_m & b_m};
			ex_pkg::alu_or:  raw = {1'b0, a_m | b_m};
			ex_pkg::alu_xor: raw = {1'b0, a_m ^ b_m};
			default:         raw = {1'b0, b_m};
		endcase
	end

	assign alu_res  = raw[`EX_WORD_W-1:0] & mask;
	assign is_arith = ctrl.alu_op inside {ex_pkg::alu_add, ex_pkg::alu_adc,
		ex_pkg::alu_sub, ex_pkg::alu_sbb};
	assign is_sub   = ctrl.alu_op inside {ex_pkg::alu_sub, ex_pkg::alu_sbb};
	assign a_top    = top_bit(a_m, ctrl.size);
	assign b_top    = top_bit(b_m, ctrl.size);
	assign r_top    = top_bit(alu_res, ctrl.size);

	// untouched flag bits pass through from the forwarded word
	always_comb begin
		alu_flags = flags_fwd;
		alu_flags[`EX_FLAG_ZF] = (alu_res == '0);
		alu_flags[`EX_FLAG_SF] = r_top;
		if (is_arith) begin
			alu_flags[`EX_FLAG_CF] = carry_bit(raw, ctrl.size);
			// carry out of bit 3
			alu_flags[`EX_FLAG_AF] = a_m[4] ^ b_m[4] ^ alu_res[4];
			if (is_sub) begin
				alu_flags[`EX_FLAG_OF] = (a_top != b_top) && (r_top != a_top);
			end else begin
				alu_flags[`EX_FLAG_OF] = (a_top == b_top) && (r_top != a_top);
			end
		end else begin
			alu_flags[`EX_FLAG_CF] = 1'b0;
			alu_flags[`EX_FLAG_AF] = 1'b0;
			alu_flags[`EX_FLAG_OF] = 1'b0;
		end
	end

	// --------------------
	// shifter
	// --------------------
	assign shamt    = ex_b[4:0];
	assign shl_wide = {{`EX_WORD_W{1'b0}}, a_m} << shamt;
	// guard bit below the lsb catches the last bit out on shr
	assign shr_wide = {a_m, 1'b0} >> shamt;

	always_comb begin
		if (ctrl.alu_op[0]) begin
			shift_res = shr_wide[`EX_WORD_W:1];
			shift_cf  = shr_wide[0];
		end else begin
			shift_res = shl_wide[`EX_WORD_W-1:0] & mask;
			shift_cf  = carry_bit(shl_wide[`EX_WORD_W:0], ctrl.size);
		end
		shift_flags = flags_fwd;
		// zero count leaves the flags alone
		if (shamt != '0) begin
			shift_flags[`EX_FLAG_CF] = shift_cf;
			shift_flags[`EX_FLAG_ZF] = (shift_res == '0);
			shift_flags[`EX_FLAG_SF] = top_bit(shift_res, ctrl.size);
		end
	end

	// --------------------
	// packed mmx adder
	// --------------------

	// lanes wrap independently
	always_comb begin
		mm_res = '0;
		case (ctrl.mm_op)
			ex_pkg::mm_paddb: begin
				for (int i = 0; i < `EX_MM_W / 8; i++) begin
					mm_res[i*8 +: 8] = ex_mm_a[i*8 +: 8] + ex_mm_b[i*8 +: 8];
				end
			end
			ex_pkg::mm_paddw: begin
				for (int i = 0; i < `EX_MM_W / 16; i++) begin
					mm_res[i*16 +: 16] = ex_mm_a[i*16 +: 16] + ex_mm_b[i*16 +: 16];
				end
			end
			ex_pkg::mm_paddd: begin
				for (int i = 0; i < `EX_MM_W / 32; i++) begin
					mm_res[i*32 +: 32] = ex_mm_a[i*32 +: 32] + ex_mm_b[i*32 +: 32];
				end
			end
			default: begin
				mm_res = ex_mm_a & ex_mm_b;
			end
		endcase
	end

	// --------------------
	// count and stack pointer
	// --------------------
	always_comb begin
		case (ctrl.size)
			ex_pkg::size_byte:  pop_inc = 32'd1;
			ex_pkg::size_word:  pop_inc = 32'd2;
			ex_pkg::size_dword: pop_inc = 32'd4;
			default:            pop_inc = 32'd8;
		endcase
	end

	assign fu.alu32_result    = alu_res;
	assign fu.alu32_flags     = alu_flags;
	assign fu.alu64_result    = mm_res;
	assign fu.shift_result    = shift_res;
	assign fu.shift_flags     = shift_flags;
	assign fu.count_minus_one = count - 32'd1;
	assign fu.sp_pop          = ex_c + pop_inc;

endmodule

`default_nettype wire

// ==== design/result_select_ex.sv ====
// next writeback value selection for results A, B, C, flags and MM
`default_nettype none

`include "ex_consts.svh"

module result_select_ex (
	input  ex_pkg::ex_ctrl_t      ctrl,
	input  logic [`EX_WORD_W-1:0] ex_a,
	input  logic [`EX_WORD_W-1:0] ex_b,
	input  logic [`EX_WORD_W-1:0] ex_c,
	fu_results_if.consumer        fu,
	output ex_pkg::wb_data_t      next_data
);

	// --------------------
	// result a
	// --------------------

	// priority follows the mux chain, alu result wins
	always_comb begin
		if (ctrl.is_alu32) begin
			next_data.result_a = fu.alu32_result;
		end else if (ctrl.is_cmps_first || ctrl.is_xchg) begin
			next_data.result_a = ex_b;
		end else if (ctrl.pass_a) begin
			next_data.result_a = ex_a;
		end else if (ctrl.is_cmpxchg) begin
			next_data.result_a = ex_c;
		end else begin
			next_data.result_a = fu.shift_result;
		end
	end

	// --------------------
	// results b and c
	// --------------------
	always_comb begin
		if (ctrl.alu_to_b) begin
			next_data.result_b = fu.alu32_result;
		end else if (ctrl.is_cmpxchg || ctrl.is_xchg) begin
			next_data.result_b = ex_a;
		end else begin
			next_data.result_b = ex_b;
		end
	end

	// count decrement for cmps, pop for stack ops
	always_comb begin
		if (ctrl.is_cmps_second) begin
			next_data.result_c = fu.count_minus_one;
		end else if (ctrl.mux_sp_pop) begin
			next_data.result_c = fu.sp_pop;
		end else begin
			next_data.result_c = ex_c;
		end
	end

	// --------------------
	// flags and mm
	// --------------------
	always_comb begin
		next_data.flags     = ctrl.alu32_flags_sel ? fu.alu32_flags : fu.shift_flags;
		next_data.result_mm = fu.alu64_result;
	end

endmodule

`default_nettype wire

// ==== design/wb_control_ex.sv ====
// cmpxchg write decision, valid gating of write enables and next valid under repne
`default_nettype none

`include "ex_consts.svh"

module wb_control_ex (
	input  ex_pkg::ex_ctrl_t ctrl,
	input  logic             ex_valid,
	input  logic             repne_terminate,
	fu_results_if.consumer   fu,
	output ex_pkg::wb_ctrl_t next_ctrl
);

	logic zf;
	logic ld_gpr1;
	logic ld_gpr2;
	logic dcache_write;

	// equal compare in cmpxchg shows up as ZF
	assign zf = fu.alu32_flags[`EX_FLAG_ZF];

	// --------------------
	// cmpxchg decision
	// --------------------

	// on match write the destination, else load the accumulator
	always_comb begin
		ld_gpr1      = ctrl.ld_gpr1;
		ld_gpr2      = ctrl.ld_gpr2;
		dcache_write = ctrl.dcache_write;
		if (ctrl.is_cmpxchg) begin
			ld_gpr1      = ctrl.ld_gpr1 && zf;
			ld_gpr2      = !zf;
			dcache_write = ctrl.dcache_write && zf;
		end
	end

	// --------------------
	// validation
	// --------------------
	always_comb begin
		next_ctrl.ld_gpr1      = ex_valid && ld_gpr1;
		next_ctrl.ld_gpr2      = ex_valid && ld_gpr2;
		next_ctrl.ld_gpr3      = ex_valid && ctrl.ld_gpr3;
		next_ctrl.ld_seg       = ex_valid && ctrl.ld_seg;
		next_ctrl.ld_mm        = ex_valid && ctrl.ld_mm;
		next_ctrl.dcache_write = ex_valid && dcache_write;
		// repne iterations only reach wb once terminated
		if (ctrl.repne) begin
			next_ctrl.valid = ex_valid && repne_terminate;
		end else begin
			next_ctrl.valid = ex_valid;
		end
	end

endmodule

`default_nettype wire

// ==== design/ex_stage.sv ====
// execute stage top level with the EX/WB data and control latches
`default_nettype none

`include "ex_consts.svh"

module ex_stage (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ex_valid,
	input  ex_pkg::ex_ctrl_t      ex_ctrl,
	input  logic [`EX_WORD_W-1:0] ex_a,
	input  logic [`EX_WORD_W-1:0] ex_b,
	input  logic [`EX_WORD_W-1:0] ex_c,
	input  logic [`EX_MM_W-1:0]   ex_mm_a,
	input  logic [`EX_MM_W-1:0]   ex_mm_b,
	input  logic [`EX_WORD_W-1:0] count_fwd,
	input  logic [`EX_WORD_W-1:0] flags_fwd,
	input  logic                  repne_terminate,
	input  logic                  wb_stall,
	output logic                  wb_valid,
	output logic                  wb_ld_gpr1,
	output logic                  wb_ld_gpr2,
	output logic                  wb_ld_gpr3,
	output logic                  wb_ld_seg,
	output logic                  wb_ld_mm,
	output logic                  wb_dcache_write,
	output logic [`EX_WORD_W-1:0] wb_result_a,
	output logic [`EX_WORD_W-1:0] wb_result_b,
	output logic [`EX_WORD_W-1:0] wb_result_c,
	output logic [`EX_WORD_W-1:0] wb_flags,
	output logic [`EX_MM_W-1:0]   wb_result_mm
);

	logic [`EX_WORD_W-1:0] b;
	logic [`EX_WORD_W-1:0] count;
	ex_pkg::wb_data_t      next_data;
	ex_pkg::wb_data_t      data_q;
	ex_pkg::wb_ctrl_t      next_ctrl;
	ex_pkg::wb_ctrl_t      ctrl_q;

	fu_results_if u_fu_results ();

	// --------------------
	// combinational datapath
	// --------------------
	operand_select_ex u_operand_select (
		.clk       (clk),
		.rst       (rst),
		.ex_valid  (ex_valid),
		.wb_stall  (wb_stall),
		.ctrl      (ex_ctrl),
		.ex_a      (ex_a),
		.ex_b      (ex_b),
		.ex_c      (ex_c),
		.count_fwd (count_fwd),
		.b         (b),
		.count     (count)
	);

	functional_unit_ex u_functional_unit (
		.ctrl      (ex_ctrl),
		.ex_a      (ex_a),
		.ex_b      (ex_b),
		.ex_c      (ex_c),
		.b         (b),
		.count     (count),
		.flags_fwd (flags_fwd),
		.ex_mm_a   (ex_mm_a),
		.ex_mm_b   (ex_mm_b),
		.fu        (u_fu_results.producer)
	);

	result_select_ex u_result_select (
		.ctrl      (ex_ctrl),
		.ex_a      (ex_a),
		.ex_b      (ex_b),
		.ex_c      (ex_c),
		.fu        (u_fu_results.consumer),
		.next_data (next_data)
	);

	wb_control_ex u_wb_control (
		.ctrl            (ex_ctrl),
		.ex_valid        (ex_valid),
		.repne_terminate (repne_terminate),
		.fu              (u_fu_results.consumer),
		.next_ctrl       (next_ctrl)
	);

	// --------------------
	// EX/WB latches
	// --------------------

	// both latches freeze together on a writeback stall
	stage_latch #(.payload_t(ex_pkg::wb_data_t)) u_data_latch (
		.clk  (clk),
		.rst  (rst),
		.load (!wb_stall),
		.d    (next_data),
		.q    (data_q)
	);

	stage_latch #(.payload_t(ex_pkg::wb_ctrl_t)) u_ctrl_latch (
		.clk  (clk),
		.rst  (rst),
		.load (!wb_stall),
		.d    (next_ctrl),
		.q    (ctrl_q)
	);

	assign wb_valid        = ctrl_q.valid;
	assign wb_ld_gpr1      = ctrl_q.ld_gpr1;
	assign wb_ld_gpr2      = ctrl_q.ld_gpr2;
	assign wb_ld_gpr3      = ctrl_q.ld_gpr3;
	assign wb_ld_seg       = ctrl_q.ld_seg;
	assign wb_ld_mm        = ctrl_q.ld_mm;
	assign wb_dcache_write = ctrl_q.dcache_write;
	assign wb_result_a     = data_q.result_a;
	assign wb_result_b     = data_q.result_b;
	assign wb_result_c     = data_q.result_c;
	assign wb_flags        = data_q.flags;
	assign wb_result_mm    = data_q.result_mm;

endmodule

`default_nettype wire

// ==== tb/ex_ref_pkg.sv ====
// reference model for operand selection, functional units, result selection and write enables
`default_nettype none

`include "ex_consts.svh"

package ex_ref_pkg;

	// quad runs as dword on the 32-bit path
	function automatic int size_bits(input ex_pkg::data_size_e size);
		case (size)
			ex_pkg::size_byte: return 8;
			ex_pkg::size_word: return 16;
			default:           return 32;
		endcase
	endfunction

	function automatic logic [`EX_WORD_W-1:0] select_b(input ex_pkg::ex_ctrl_t ctrl,
		input logic [`EX_WORD_W-1:0] temp,
		input logic [`EX_WORD_W-1:0] ex_b);
		return ctrl.is_cmps_second ? temp : ex_b;
	endfunction

	// --------------------
	// alu and shifter
	// --------------------
	function automatic void alu_model(input ex_pkg::ex_ctrl_t ctrl,
		input logic [`EX_WORD_W-1:0] a_in,
		input logic [`EX_WORD_W-1:0] b_in,
		input logic [`EX_WORD_W-1:0] flags_in,
		output logic [`EX_WORD_W-1:0] res,
		output logic [`EX_WORD_W-1:0] flags);
		int          w;
		logic [63:0] mask;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] full;
		logic        ci;
		logic        cin;
		logic [4:0]  nib;
		longint      s_a;
		longint      s_b;
		longint      s_full;
		longint      s_lim;
		w    = size_bits(ctrl.size);
		mask = (64'd1 << w) - 64'd1;
		a    = a_in & mask;
		b    = b_in & mask;
		ci   = flags_in[`EX_FLAG_CF];
		cin  = (ctrl.alu_op inside {ex_pkg::alu_adc, ex_pkg::alu_sbb}) ? ci : 1'b0;
		case (ctrl.alu_op)
			ex_pkg::alu_add: full = a + b;
			ex_pkg::alu_adc: full = a + b + ci;
			ex_pkg::alu_sub: full = a - b;
			ex_pkg::alu_sbb: full = a - b - ci;
			ex_pkg::alu_and: full = a & b;
			ex_pkg::alu_or:  full = a | b;
			ex_pkg::alu_xor: full = a ^ b;
			default:         full = b;
		endcase
		res   = full[`EX_WORD_W-1:0] & mask[`EX_WORD_W-1:0];
		// signed views of the operands at the selected width
		s_lim = longint'(1) <<< (w - 1);
		s_a   = a[w-1] ? longint'(a) - 2 * s_lim : longint'(a);
		s_b   = b[w-1] ? longint'(b) - 2 * s_lim : longint'(b);
		flags = flags_in;
		flags[`EX_FLAG_ZF] = (res == '0);
		flags[`EX_FLAG_SF] = res[w-1];
		flags[`EX_FLAG_CF] = 1'b0;
		flags[`EX_FLAG_AF] = 1'b0;
		flags[`EX_FLAG_OF] = 1'b0;
		if (ctrl.alu_op inside {ex_pkg::alu_add, ex_pkg::alu_adc,
			ex_pkg::alu_sub, ex_pkg::alu_sbb}) begin
			// carry or borrow lands just above the operand width
			flags[`EX_FLAG_CF] = full[w];
			if (ctrl.alu_op inside {ex_pkg::alu_sub, ex_pkg::alu_sbb}) begin
				nib    = {1'b0, a[3:0]} - {1'b0, b[3:0]} - cin;
				s_full = s_a - s_b - longint'(cin);
			end else begin
				nib    = {1'b0, a[3:0]} + {1'b0, b[3:0]} + cin;
				s_full = s_a + s_b + longint'(cin);
			end
			// carry or borrow out of the low nibble
			flags[`EX_FLAG_AF] = nib[4];
			// signed result outside the range of the width
			flags[`EX_FLAG_OF] = (s_full >= s_lim) || (s_full < -s_lim);
		end
	endfunction

	function automatic void shift_model(input ex_pkg::ex_ctrl_t ctrl,
		input logic [`EX_WORD_W-1:0] a_in,
		input logic [`EX_WORD_W-1:0] b_in,
		input logic [`EX_WORD_W-1:0] flags_in,
		output logic [`EX_WORD_W-1:0] res,
		output logic [`EX_WORD_W-1:0] flags);
		int          w;
		int          sh;
		logic [63:0] mask;
		logic [63:0] a;
		logic [63:0] wide;
		logic        cf;
		w    = size_bits(ctrl.size);
		mask = (64'd1 << w) - 64'd1;
		a    = a_in & mask;
		sh   = b_in[4:0];
		if (ctrl.alu_op[0]) begin
			wide = a >> sh;
			res  = wide[`EX_WORD_W-1:0];
			// last bit out of a right shift sits at sh-1
			wide = (sh == 0) ? 64'd0 : (a >> (sh - 1));
			cf   = wide[0];
		end else begin
			wide = a << sh;
			res  = wide[`EX_WORD_W-1:0] & mask[`EX_WORD_W-1:0];
			cf   = wide[w];
		end
		flags = flags_in;
		if (sh != 0) begin
			flags[`EX_FLAG_CF] = cf;
			flags[`EX_FLAG_ZF] = (res == '0);
			flags[`EX_FLAG_SF] = res[w-1];
		end
	endfunction

	// byte-wide adds with the carry cut at every lane boundary
	function automatic logic [`EX_MM_W-1:0] mm_model(input ex_pkg::mm_op_e op,
		input logic [`EX_MM_W-1:0] a,
		input logic [`EX_MM_W-1:0] b);
		logic [`EX_MM_W-1:0] r;
		logic [8:0]          s9;
		logic                carry;
		int                  lane;
		if (op == ex_pkg::mm_pand) begin
			return a & b;
		end
		lane  = (op == ex_pkg::mm_paddb) ? 8 : (op == ex_pkg::mm_paddw) ? 16 : 32;
		carry = 1'b0;
		for (int k = 0; k < `EX_MM_W / 8; k++) begin
			s9 = {1'b0, a[k*8 +: 8]} + {1'b0, b[k*8 +: 8]} + carry;
			r[k*8 +: 8] = s9[7:0];
			carry = (((k + 1) * 8) % lane == 0) ? 1'b0 : s9[8];
		end
		return r;
	endfunction

	// --------------------
	// next EX/WB values
	// --------------------
	function automatic ex_pkg::wb_data_t next_data(input ex_pkg::ex_ctrl_t ctrl,
		input logic [`EX_WORD_W-1:0] ex_a,
		input logic [`EX_WORD_W-1:0] ex_b,
		input logic [`EX_WORD_W-1:0] ex_c,
		input logic [`EX_WORD_W-1:0] b_sel,
		input logic [`EX_WORD_W-1:0] count_fwd,
		input logic [`EX_WORD_W-1:0] flags_fwd,
		input logic [`EX_MM_W-1:0] mm_a,
		input logic [`EX_MM_W-1:0] mm_b);
		ex_pkg::wb_data_t      d;
		logic [`EX_WORD_W-1:0] alu_res;
		logic [`EX_WORD_W-1:0] alu_flags;
		logic [`EX_WORD_W-1:0] sh_res;
		logic [`EX_WORD_W-1:0] sh_flags;
		logic [`EX_WORD_W-1:0] count;
		alu_model(ctrl, ex_a, b_sel, flags_fwd, alu_res, alu_flags);
		shift_model(ctrl, ex_a, ex_b, flags_fwd, sh_res, sh_flags);
		count = ctrl.repne_steady ? count_fwd : ex_c;
		if (ctrl.is_alu32) begin
			d.result_a = alu_res;
		end else if (ctrl.is_cmps_first || ctrl.is_xchg) begin
			d.result_a = ex_b;
		end else if (ctrl.pass_a) begin
			d.result_a = ex_a;
		end else if (ctrl.is_cmpxchg) begin
			d.result_a = ex_c;
		end else begin
			d.result_a = sh_res;
		end
		if (ctrl.alu_to_b) begin
			d.result_b = alu_res;
		end else if (ctrl.is_cmpxchg || ctrl.is_xchg) begin
			d.result_b = ex_a;
		end else begin
			d.result_b = ex_b;
		end
		if (ctrl.is_cmps_second) begin
			d.result_c = count - 1;
		end else if (ctrl.mux_sp_pop) begin
			d.result_c = ex_c + (32'd1 << ctrl.size);
		end else begin
			d.result_c = ex_c;
		end
		d.flags     = ctrl.alu32_flags_sel ? alu_flags : sh_flags;
		d.result_mm = mm_model(ctrl.mm_op, mm_a, mm_b);
		return d;
	endfunction

	function automatic ex_pkg::wb_ctrl_t next_ctrl(input ex_pkg::ex_ctrl_t ctrl,
		input logic ex_valid,
		input logic repne_terminate,
		input logic [`EX_WORD_W-1:0] ex_a,
		input logic [`EX_WORD_W-1:0] b_sel,
		input logic [`EX_WORD_W-1:0] flags_fwd);
		ex_pkg::wb_ctrl_t      c;
		logic [`EX_WORD_W-1:0] alu_res;
		logic [`EX_WORD_W-1:0] alu_flags;
		logic                  zf;
		alu_model(ctrl, ex_a, b_sel, flags_fwd, alu_res, alu_flags);
		zf             = alu_flags[`EX_FLAG_ZF];
		c.ld_gpr1      = ctrl.ld_gpr1;
		c.ld_gpr2      = ctrl.ld_gpr2;
		c.ld_gpr3      = ctrl.ld_gpr3;
		c.ld_seg       = ctrl.ld_seg;
		c.ld_mm        = ctrl.ld_mm;
		c.dcache_write = ctrl.dcache_write;
		if (ctrl.is_cmpxchg) begin
			c.ld_gpr1      = ctrl.ld_gpr1 && zf;
			c.ld_gpr2      = !zf;
			c.dcache_write = ctrl.dcache_write && zf;
		end
		c.valid = !ctrl.repne || repne_terminate;
		// an invalid slot writes nothing
		if (!ex_valid) begin
			c = '0;
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// ==== tb/ex_stage_tb.sv ====
// testbench for ex_stage with seeded random micro-ops, stall injection and a reference model
`default_nettype none

`include "ex_consts.svh"

module ex_stage_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_CYCLES    = 4000;
	localparam int RESET_TIMEOUT = 8;

	logic                  clk;
	logic                  rst;
	logic                  ex_valid;
	ex_pkg::ex_ctrl_t      ex_ctrl;
	logic [`EX_WORD_W-1:0] ex_a;
	logic [`EX_WORD_W-1:0] ex_b;
	logic [`EX_WORD_W-1:0] ex_c;
	logic [`EX_MM_W-1:0]   ex_mm_a;
	logic [`EX_MM_W-1:0]   ex_mm_b;
	logic [`EX_WORD_W-1:0] count_fwd;
	logic [`EX_WORD_W-1:0] flags_fwd;
	logic                  repne_terminate;
	logic                  wb_stall;
	logic                  wb_valid;
	logic                  wb_ld_gpr1;
	logic                  wb_ld_gpr2;
	logic                  wb_ld_gpr3;
	logic                  wb_ld_seg;
	logic                  wb_ld_mm;
	logic                  wb_dcache_write;
	logic [`EX_WORD_W-1:0] wb_result_a;
	logic [`EX_WORD_W-1:0] wb_result_b;
	logic [`EX_WORD_W-1:0] wb_result_c;
	logic [`EX_WORD_W-1:0] wb_flags;
	logic [`EX_MM_W-1:0]   wb_result_mm;

	// expected latch contents held across stalls like the DUT
	ex_pkg::wb_data_t      exp_data;
	ex_pkg::wb_ctrl_t      exp_ctrl;
	logic [`EX_WORD_W-1:0] temp_model;
	int                    mismatch_count;
	int                    other_count;
	int                    waited;

	ex_stage u_ex_stage (
		.clk             (clk),
		.rst             (rst),
		.ex_valid        (ex_valid),
		.ex_ctrl         (ex_ctrl),
		.ex_a            (ex_a),
		.ex_b            (ex_b),
		.ex_c            (ex_c),
		.ex_mm_a         (ex_mm_a),
		.ex_mm_b         (ex_mm_b),
		.count_fwd       (count_fwd),
		.flags_fwd       (flags_fwd),
		.repne_terminate (repne_terminate),
		.wb_stall        (wb_stall),
		.wb_valid        (wb_valid),
		.wb_ld_gpr1      (wb_ld_gpr1),
		.wb_ld_gpr2      (wb_ld_gpr2),
		.wb_ld_gpr3      (wb_ld_gpr3),
		.wb_ld_seg       (wb_ld_seg),
		.wb_ld_mm        (wb_ld_mm),
		.wb_dcache_write (wb_dcache_write),
		.wb_result_a     (wb_result_a),
		.wb_result_b     (wb_result_b),
		.wb_result_c     (wb_result_c),
		.wb_flags        (wb_flags),
		.wb_result_mm    (wb_result_mm)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// --------------------
	// compare tasks
	// --------------------
	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
		mismatch_count++;
	endtask

	task automatic check_data(input ex_pkg::wb_data_t exp, input ex_pkg::wb_data_t act);
		if (act.result_a !== exp.result_a) begin
			report_mismatch("wb_result_a", exp.result_a, act.result_a);
		end
		if (act.result_b !== exp.result_b) begin
			report_mismatch("wb_result_b", exp.result_b, act.result_b);
		end
		if (act.result_c !== exp.result_c) begin
			report_mismatch("wb_result_c", exp.result_c, act.result_c);
		end
		if (act.flags !== exp.flags) begin
			report_mismatch("wb_flags", exp.flags, act.flags);
		end
		if (act.result_mm !== exp.result_mm) begin
			report_mismatch("wb_result_mm", exp.result_mm, act.result_mm);
		end
	endtask

	task automatic check_ctrl(input ex_pkg::wb_ctrl_t exp, input ex_pkg::wb_ctrl_t act);
		if (act.valid !== exp.valid) begin
			report_mismatch("wb_valid", exp.valid, act.valid);
		end
		if (act.ld_gpr1 !== exp.ld_gpr1) begin
			report_mismatch("wb_ld_gpr1", exp.ld_gpr1, act.ld_gpr1);
		end
		if (act.ld_gpr2 !== exp.ld_gpr2) begin
			report_mismatch("wb_ld_gpr2", exp.ld_gpr2, act.ld_gpr2);
		end
		if (act.ld_gpr3 !== exp.ld_gpr3) begin
			report_mismatch("wb_ld_gpr3", exp.ld_gpr3, act.ld_gpr3);
		end
		if (act.ld_seg !== exp.ld_seg) begin
			report_mismatch("wb_ld_seg", exp.ld_seg, act.ld_seg);
		end
		if (act.ld_mm !== exp.ld_mm) begin
			report_mismatch("wb_ld_mm", exp.ld_mm, act.ld_mm);
		end
		if (act.dcache_write !== exp.dcache_write) begin
			report_mismatch("wb_dcache_write", exp.dcache_write, act.dcache_write);
		end
	endtask

	function automatic ex_pkg::wb_data_t actual_data();
		ex_pkg::wb_data_t d;
		d.result_a  = wb_result_a;
		d.result_b  = wb_result_b;
		d.result_c  = wb_result_c;
		d.flags     = wb_flags;
		d.result_mm = wb_result_mm;
		return d;
	endfunction

	function automatic ex_pkg::wb_ctrl_t actual_ctrl();
		ex_pkg::wb_ctrl_t c;
		c.valid        = wb_valid;
		c.ld_gpr1      = wb_ld_gpr1;
		c.ld_gpr2      = wb_ld_gpr2;
		c.ld_gpr3      = wb_ld_gpr3;
		c.ld_seg       = wb_ld_seg;
		c.ld_mm        = wb_ld_mm;
		c.dcache_write = wb_dcache_write;
		return c;
	endfunction

	// --------------------
	// stimulus and model
	// --------------------

	// inputs seen at this edge were driven one edge earlier
	task automatic step_model();
		logic [`EX_WORD_W-1:0] b_sel;
		b_sel    = ex_ref_pkg::select_b(ex_ctrl, temp_model, ex_b);
		exp_data = ex_ref_pkg::next_data(ex_ctrl, ex_a, ex_b, ex_c, b_sel, count_fwd,
			flags_fwd, ex_mm_a, ex_mm_b);
		exp_ctrl = ex_ref_pkg::next_ctrl(ex_ctrl, ex_valid, repne_terminate, ex_a, b_sel,
			flags_fwd);
		if (ex_valid && ex_ctrl.is_cmps_first) begin
			temp_model = ex_a;
		end
	endtask

	task automatic drive_random();
		logic [$bits(ex_pkg::ex_ctrl_t)-1:0] ctrl_bits;
		logic [`EX_WORD_W-1:0]               a;
		logic [`EX_WORD_W-1:0]               b;
		ctrl_bits = $urandom;
		a         = $urandom;
		b         = $urandom;
		// equal operands so cmpxchg sees ZF set
		if ($urandom % 4 == 0) begin
			b = a;
		end
		// zero shift count
		if ($urandom % 8 == 0) begin
			b[4:0] = '0;
		end
		ex_valid        <= ($urandom % 4) != 0;
		ex_ctrl         <= ctrl_bits;
		ex_a            <= a;
		ex_b            <= b;
		ex_c            <= $urandom;
		ex_mm_a         <= {$urandom, $urandom};
		ex_mm_b         <= {$urandom, $urandom};
		count_fwd       <= $urandom;
		flags_fwd       <= $urandom;
		repne_terminate <= $urandom % 2;
		wb_stall        <= ($urandom % 4) == 0;
	endtask

	initial begin
		mismatch_count  = 0;
		other_count     = 0;
		waited          = 0;
		exp_data        = '0;
		exp_ctrl        = '0;
		temp_model      = '0;
		void'($urandom(32'hb145));
		rst             = 1'b1;
		ex_valid        = 1'b0;
		ex_ctrl         = '0;
		ex_a            = '0;
		ex_b            = '0;
		ex_c            = '0;
		ex_mm_a         = '0;
		ex_mm_b         = '0;
		count_fwd       = '0;
		flags_fwd       = '0;
		repne_terminate = 1'b0;
		wb_stall        = 1'b0;

		repeat (3) @(posedge clk);
		rst <= 1'b0;

		while (rst !== 1'b0 && waited < RESET_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (rst !== 1'b0) begin
			$display("reset was not released within %0d cycles", RESET_TIMEOUT);
			other_count++;
		end else begin
			// latches cleared and nothing loaded yet
			check_ctrl(exp_ctrl, actual_ctrl());
			check_data(exp_data, actual_data());
			for (int i = 0; i < NUM_CYCLES; i++) begin
				@(posedge clk);
				if (!wb_stall) begin
					step_model();
				end
				drive_random();
				@(negedge clk);
				check_ctrl(exp_ctrl, actual_ctrl());
				check_data(exp_data, actual_data());
			end
		end

		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== ex_stage.f ====
+incdir+design
design/ex_pkg.sv
design/fu_results_if.sv
design/stage_latch.sv
design/operand_select_ex.sv
design/functional_unit_ex.sv
design/result_select_ex.sv
design/wb_control_ex.sv
design/ex_stage.sv
tb/ex_ref_pkg.sv
tb/ex_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

export_include_dirs:
  - design

sources:
  - design/ex_pkg.sv
  - design/fu_results_if.sv
  - design/stage_latch.sv
  - design/operand_select_ex.sv
  - design/functional_unit_ex.sv
  - design/result_select_ex.sv
  - design/wb_control_ex.sv
  - design/ex_stage.sv
  - target: test
    files:
      - tb/ex_ref_pkg.sv
      - tb/ex_stage_tb.sv
